// ==== bench/aes_patterns.hex ====
// columns: key, plaintext, expected ciphertext (128-bit hex each)
// FIPS-197 examples first, then further known-answer pairs
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
00000000000000000000000000000000 f34481ec3cc627bacd5dc3fb08f273e6 0336763e966d92595a567cc9ce537f5e
00000000000000000000000000000000 80000000000000000000000000000000 3ad78e726c1ec02b7ebfe92b23d9ec34
80000000000000000000000000000000 00000000000000000000000000000000 0edd33d3c621e546455bd8ba1418bec8

// ==== files.f ====
src/aes_types_pkg.sv
src/aes_round_pkg.sv
src/aes_sbox.sv
src/aes_key_schedule.sv
src/aes_round.sv
src/aes_control.sv
src/aes_top.sv
bench/tb_aes.sv

// ==== Makefile ====
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := tb_aes
FILELIST  := files.f
OBJ_DIR   := obj_dir
PATTERNS  := bench/aes_patterns.hex
LOG       := sim.log
FAIL_MSG  := TESTS FAILED
PASS_MSG  := TESTS PASSED

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) $(PATTERNS)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tb_aes.sv ====
`default_nettype none

module tb_aes;

    timeunit 1ns;
    timeprecision 1ps;

    import aes_types_pkg::*;
    import aes_round_pkg::*;

    localparam int          NUM_PATTERNS = 10;
    localparam int          RESET_CYCLES = 10;
    localparam int          DONE_TIMEOUT = 40;
    localparam int          MAX_GAP      = 6;
    localparam int          INJECT_EDGE  = 3;
    localparam int unsigned SEED         = 32'h092c_79c3;

    logic   clk;
    logic   arst_n;
    logic   start;
    block_t key_in;
    block_t block_in;
    block_t block_out;
    logic   busy;
    logic   done;

    // key, plaintext, ciphertext for each test
    block_t      pattern_mem [0:3*NUM_PATTERNS-1];
    logic        pre_started;
    logic        chain;

    aes_top dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .key_in    (key_in),
        .block_in  (block_in),
        .block_out (block_out),
        .busy      (busy),
        .done      (done)
    );

    always #50 clk = ~clk;

    function automatic block_t key_of(input int idx);
        return pattern_mem[3*idx];
    endfunction

    function automatic block_t plain_of(input int idx);
        return pattern_mem[3*idx+1];
    endfunction

    function automatic block_t cipher_of(input int idx);
        return pattern_mem[3*idx+2];
    endfunction

    task automatic value_error(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic done_timeout(input int idx);
        $display("Timeout: done never came for pattern %0d within %0d cycles", idx, DONE_TIMEOUT);
        $display("TESTS FAILED");
        $fatal(1, "stopped on timeout");
    endtask

    task automatic drive_pattern(input int idx);
        start    <= 1'b1;
        key_in   <= key_of(idx);
        block_in <= plain_of(idx);
    endtask

    task automatic scramble_inputs();
        start    <= 1'b0;
        key_in   <= {$urandom, $urandom, $urandom, $urandom};
        block_in <= {$urandom, $urandom, $urandom, $urandom};
    endtask

    task automatic check_idle(input block_t expected, input string where);
        assert (!busy && !done) else
            value_error($sformatf("%s: busy %b done %b, expected both low", where, busy, done));
        assert (block_out == expected) else
            value_error($sformatf("%s: block_out %h, expected %h", where, block_out, expected));
    endtask

    // one encryption from start to the done cycle
    task automatic run_block(input int idx, input logic pre, input logic inject,
                             input logic chain_next);
        int   edges;
        logic seen;
        edges = 0;
        seen  = 1'b0;
        if (!pre) begin
            @(posedge clk);
            drive_pattern(idx);
        end
        // accept edge
        @(posedge clk);
        scramble_inputs();
        while (!seen) begin
            @(negedge clk);
            if (done) begin
                seen = 1'b1;
            end else begin
                assert (busy) else
                    value_error($sformatf("pattern %0d: busy low %0d cycles after accept",
                                          idx, edges + 1));
                assert (edges < DONE_TIMEOUT) else
                    done_timeout(idx);
                @(posedge clk);
                edges++;
                if (inject && edges == INJECT_EDGE) begin
                    // start while busy, must be dropped
                    drive_pattern(idx + 1);
                end else if (chain_next && edges == NUM_ROUNDS) begin
                    // lands on the edge that ends the done cycle
                    drive_pattern(idx + 1);
                end else begin
                    start <= 1'b0;
                end
            end
        end
        assert (edges == NUM_ROUNDS) else
            value_error($sformatf("pattern %0d: done after %0d edges, expected %0d",
                                  idx, edges, NUM_ROUNDS));
        assert (!busy) else
            value_error($sformatf("pattern %0d: busy still high with done", idx));
        assert (block_out == cipher_of(idx)) else
            value_error($sformatf("pattern %0d: block_out %h, expected %h",
                                  idx, block_out, cipher_of(idx)));
    endtask

    task automatic idle_gap(input int idx);
        int gap;
        gap = $urandom_range(MAX_GAP, 1);
        for (int n = 0; n < gap; n++) begin
            @(posedge clk);
            scramble_inputs();
            @(negedge clk);
            check_idle(cipher_of(idx), $sformatf("idle after pattern %0d", idx));
        end
    endtask

    initial begin
        void'($urandom(SEED));
        clk         = 1'b0;
        arst_n      = 1'b0;
        start       = 1'b0;
        key_in      = '0;
        block_in    = '0;
        pre_started = 1'b0;
        chain       = 1'b0;
        $readmemh("bench/aes_patterns.hex", pattern_mem);

        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        for (int n = 0; n < 3; n++) begin
            @(negedge clk);
            check_idle('0, "after reset");
        end

        // odd patterns hand over to the next one in the done cycle
        for (int i = 0; i < NUM_PATTERNS; i++) begin
            chain = (i % 2 == 1) && (i + 1 < NUM_PATTERNS);
            run_block(i, pre_started, (i % 4 == 0) && (i + 1 < NUM_PATTERNS), chain);
            if (!chain) begin
                idle_gap(i);
            end
            pre_started = chain;
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/aes_top.sv ====
`default_nettype none

module aes_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  start,
    input  aes_types_pkg::block_t key_in,
    input  aes_types_pkg::block_t block_in,
    output aes_types_pkg::block_t block_out,
    output logic                  busy,
    output logic                  done
);

    import aes_types_pkg::*;

    logic   load;
    logic   advance;
    logic   last_round;
    block_t next_key;

    aes_control u_control (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .load       (load),
        .advance    (advance),
        .last_round (last_round),
        .busy       (busy),
        .done       (done)
    );

    // schedule runs one key ahead of the state
    aes_key_schedule u_key_schedule (
        .clk       (clk),
        .arst_n    (arst_n),
        .load      (load),
        .advance   (advance),
        .key_in    (key_in),
        .round_key (),
        .next_key  (next_key)
    );

    aes_round u_round (
        .clk        (clk),
        .arst_n     (arst_n),
        .load       (load),
        .advance    (advance),
        .last_round (last_round),
        .block_in   (block_in),
        .key_in     (key_in),
        .next_key   (next_key),
        .block_out  (block_out)
    );

endmodule

`default_nettype wire

// ==== src/aes_control.sv ====
`default_nettype none

module aes_control (
    input  logic clk,
    input  logic arst_n,
    input  logic start,
    output logic load,
    output logic advance,
    output logic last_round,
    output logic busy,
    output logic done
);

    import aes_round_pkg::*;

    logic [ROUND_CNT_W-1:0] round_cnt;

    // start while busy is dropped
    assign load       = start & ~busy;
    assign advance    = busy;
    assign last_round = (round_cnt == ROUND_CNT_W'(NUM_ROUNDS));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            round_cnt <= '0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (load) begin
                round_cnt <= ROUND_CNT_W'(1);
                busy      <= 1'b1;
            end else if (busy) begin
                if (last_round) begin
                    // round 10 written at this edge
                    round_cnt <= '0;
                    busy      <= 1'b0;
                    done      <= 1'b1;
                end else begin
                    round_cnt <= round_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/aes_round.sv ====
`default_nettype none

module aes_round (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  load,
    input  logic                  advance,
    input  logic                  last_round,
    input  aes_types_pkg::block_t block_in,
    input  aes_types_pkg::block_t key_in,
    input  aes_types_pkg::block_t next_key,
    output aes_types_pkg::block_t block_out
);

    import aes_types_pkg::*;
    import aes_round_pkg::*;

    block_t      state;
    wire block_t sub;
    block_t      shifted;
    block_t      mixed;
    block_t      round_out;

    // one column times the fixed {02 03 01 01} circulant
    function automatic word_t mix_column(input word_t col);
        byte_t a0;
        byte_t a1;
        byte_t a2;
        byte_t a3;
        a0 = col[WORD_W-1 -: BYTE_W];
        a1 = col[WORD_W-1-BYTE_W -: BYTE_W];
        a2 = col[WORD_W-1-2*BYTE_W -: BYTE_W];
        a3 = col[BYTE_W-1:0];
        return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    endfunction

    for (genvar k = 0; k < BLOCK_BYTES; k++) begin : g_sub
        aes_sbox u_sbox (
            .in  (state[BLOCK_W-1-k*BYTE_W -: BYTE_W]),
            .out (sub[BLOCK_W-1-k*BYTE_W -: BYTE_W])
        );
    end

    // row r moves left by r columns
    always_comb begin
        for (int c = 0; c < BLOCK_WORDS; c++) begin
            for (int r = 0; r < WORD_BYTES; r++) begin
                shifted[BLOCK_W-1-(WORD_BYTES*c+r)*BYTE_W -: BYTE_W] =
                    sub[BLOCK_W-1-(WORD_BYTES*((c+r)%BLOCK_WORDS)+r)*BYTE_W -: BYTE_W];
            end
        end
    end

    always_comb begin
        for (int c = 0; c < BLOCK_WORDS; c++) begin
            mixed[BLOCK_W-1-c*WORD_W -: WORD_W] =
                mix_column(shifted[BLOCK_W-1-c*WORD_W -: WORD_W]);
        end
    end

    // final round has no column mixing
    assign round_out = (last_round ? shifted : mixed) ^ next_key;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= '0;
        end else if (load) begin
            state <= block_in ^ key_in;
        end else if (advance) begin
            state <= round_out;
        end
    end

    assign block_out = state;

endmodule

`default_nettype wire

// ==== src/aes_key_schedule.sv ====
`default_nettype none

module aes_key_schedule (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  load,
    input  logic                  advance,
    input  aes_types_pkg::block_t key_in,
    output aes_types_pkg::block_t round_key,
    output aes_types_pkg::block_t next_key
);

    import aes_types_pkg::*;
    import aes_round_pkg::*;

    byte_t      rcon;
    word_t      rot;
    wire word_t sub;

    // last word of the current key, rotated
    assign rot = rot_word(round_key[WORD_W-1:0]);

    for (genvar b = 0; b < WORD_BYTES; b++) begin : g_sub
        aes_sbox u_sbox (
            .in  (rot[b*BYTE_W +: BYTE_W]),
            .out (sub[b*BYTE_W +: BYTE_W])
        );
    end

    // w0' = w0 ^ g(w3), then each word xors the new word before it
    always_comb begin
        word_t chain;
        chain = sub ^ {rcon, {(WORD_W-BYTE_W){1'b0}}};
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            chain = chain ^ round_key[BLOCK_W-1-i*WORD_W -: WORD_W];
            next_key[BLOCK_W-1-i*WORD_W -: WORD_W] = chain;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rcon <= '0;
        end else if (load) begin
            rcon <= RCON_INIT;
        end else if (advance) begin
            rcon <= xtime(rcon);
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            round_key <= key_in;
        end else if (advance) begin
            round_key <= next_key;
        end
    end

endmodule

`default_nettype wire

// ==== src/aes_sbox.sv ====
`default_nettype none

module aes_sbox (
    input  aes_types_pkg::byte_t in,
    output aes_types_pkg::byte_t out
);

    import aes_types_pkg::*;
    import aes_round_pkg::*;

    byte_t inv;

    function automatic byte_t rotl(input byte_t b, input int n);
        return (b << n) | (b >> (BYTE_W - n));
    endfunction

    // inverse as x^254 = x^2 * x^4 * ... * x^128
    // zero has no inverse and falls out as zero here
    always_comb begin
        byte_t sq;
        sq  = in;
        inv = 8'h01;
        for (int k = 1; k < BYTE_W; k++) begin
            sq  = gf_mul(sq, sq);
            inv = gf_mul(inv, sq);
        end
    end

    // affine map: bit i gets bits i, i+4, i+5, i+6, i+7 of the inverse
    assign out = inv
               ^ rotl(inv, 1)
               ^ rotl(inv, 2)
               ^ rotl(inv, 3)
               ^ rotl(inv, 4)
               ^ AFFINE_C;

endmodule

`default_nettype wire

// ==== src/aes_round_pkg.sv ====
`default_nettype none

package aes_round_pkg;

    import aes_types_pkg::*;

    localparam int NUM_ROUNDS  = 10;
    localparam int ROUND_CNT_W = $clog2(NUM_ROUNDS + 1);

    localparam byte_t RCON_INIT = 8'h01;

    // x^8 + x^4 + x^3 + x + 1, top bit dropped
    localparam byte_t GF_POLY = 8'h1b;

    // constant term of the s-box affine map
    localparam byte_t AFFINE_C = 8'h63;

    // multiply by x in GF(2^8)
    function automatic byte_t xtime(input byte_t a);
        byte_t shifted;
        shifted = {a[BYTE_W-2:0], 1'b0};
        if (a[BYTE_W-1]) begin
            shifted = shifted ^ GF_POLY;
        end
        return shifted;
    endfunction

    // shift-and-add product, one bit of b per step
    function automatic byte_t gf_mul(input byte_t a, input byte_t b);
        byte_t acc;
        byte_t term;
        acc  = '0;
        term = a;
        for (int i = 0; i < BYTE_W; i++) begin
            if (b[i]) begin
                acc = acc ^ term;
            end
            term = xtime(term);
        end
        return acc;
    endfunction

    // {a0, a1, a2, a3} -> {a1, a2, a3, a0}
    function automatic word_t rot_word(input word_t w);
        return {w[WORD_W-BYTE_W-1:0], w[WORD_W-1 -: BYTE_W]};
    endfunction

endpackage

`default_nettype wire

// ==== src/aes_types_pkg.sv ====
`default_nettype none

package aes_types_pkg;

    localparam int BYTE_W  = 8;
    localparam int WORD_W  = 32;
    localparam int BLOCK_W = 128;

    localparam int WORD_BYTES  = WORD_W / BYTE_W;
    localparam int BLOCK_WORDS = BLOCK_W / WORD_W;
    localparam int BLOCK_BYTES = BLOCK_W / BYTE_W;

    // byte 0 sits in the top bits of a block
    // state is stored column by column, four bytes per column
    typedef logic [BYTE_W-1:0]  byte_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [BLOCK_W-1:0] block_t;

endpackage

`default_nettype wire
